//--- bench/stage_dispatch_assertions.sv
`timescale 1ns/1ns

module stage_dispatch_assertions #(
    parameter int ROB_DEPTH = 8,
    localparam int TAG_W = $clog2(ROB_DEPTH)
) (
    input logic                    clock,
    input logic                    reset,
    input logic                    stall,
    input logic                    fu_busy,
    input logic                    cdb_valid,
    input logic                    issue_valid,
    input logic [TAG_W-1:0]        issue_tag,
    input ooo_pkg::word_t          issue_opa,
    input ooo_pkg::word_t          issue_opb,
    input rv32_isa_pkg::alu_func_t issue_func,
    input logic                    retire_valid
);

    int unsigned failures = 0;
    // broadcasts seen but not yet retired
    int          completed;

    always @(posedge clock) begin
        if (reset) begin
            completed <= 0;
        end else begin
            completed <= completed + int'(cdb_valid) - int'(retire_valid);
        end
    end

    reset_clears_outputs: assert property (@(posedge clock)
        reset |=> !stall && !issue_valid && !retire_valid)
        else begin
            failures++;
            $error("stall, issue_valid or retire_valid is high right after reset");
        end

    issue_held_while_busy: assert property (@(posedge clock) disable iff (reset)
        issue_valid && fu_busy |=> issue_valid && $stable(issue_tag)
            && $stable(issue_opa) && $stable(issue_opb) && $stable(issue_func))
        else begin
            failures++;
            $error("issued operation changed or dropped while the functional unit was busy");
        end

    busy_fu_stalls_dispatch: assert property (@(posedge clock) disable iff (reset)
        issue_valid && fu_busy |=> stall)
        else begin
            failures++;
            $error("station freed at an edge where the functional unit was busy");
        end

    retire_after_completion: assert property (@(posedge clock) disable iff (reset)
        retire_valid |-> completed > 0)
        else begin
            failures++;
            $error("retirement without an earlier result broadcast on the CDB");
        end

endmodule

//--- bench/stage_dispatch_tb.sv
`timescale 1ns/1ns

module stage_dispatch_tb;
    import ooo_pkg::*;
    import rv32_isa_pkg::*;

    localparam int ROB_DEPTH   = 8;
    localparam int TAG_W       = $clog2(ROB_DEPTH);
    localparam int NUM_INSTS   = 300;
    localparam int CYCLE_LIMIT = NUM_INSTS * 12;

    logic             clock;
    logic             reset;
    logic             inst_valid;
    inst_t            inst;
    word_t            pc;
    logic             fu_busy;
    logic             cdb_valid;
    logic [TAG_W-1:0] cdb_tag;
    word_t            cdb_value;
    logic             stall;
    logic             issue_valid;
    logic [TAG_W-1:0] issue_tag;
    word_t            issue_opa;
    word_t            issue_opb;
    alu_func_t        issue_func;
    logic             retire_valid;
    reg_idx_t         retire_reg;
    word_t            retire_value;

    logic [31:0]      stim_lfsr;
    logic [31:0]      fu_lfsr;
    int               cycle = 0;
    int               accepted;
    int               retired;
    word_t            gold_regs [NUM_ARCH_REGS];
    reg_idx_t         exp_reg [$];
    word_t            exp_value [$];
    logic [TAG_W-1:0] fu_tag [$];
    word_t            fu_value [$];
    int               fu_due [$];

    stage_dispatch #(.ROB_DEPTH(ROB_DEPTH)) UUT (
        .clock        (clock),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .pc           (pc),
        .fu_busy      (fu_busy),
        .cdb_valid    (cdb_valid),
        .cdb_tag      (cdb_tag),
        .cdb_value    (cdb_value),
        .stall        (stall),
        .issue_valid  (issue_valid),
        .issue_tag    (issue_tag),
        .issue_opa    (issue_opa),
        .issue_opb    (issue_opb),
        .issue_func   (issue_func),
        .retire_valid (retire_valid),
        .retire_reg   (retire_reg),
        .retire_value (retire_value)
    );

    bind stage_dispatch stage_dispatch_assertions #(.ROB_DEPTH(ROB_DEPTH)) protocol_checks (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] draw(inout logic [31:0] state, input int nbits);
        logic [31:0] bits;
        bits = '0;
        for (int k = 0; k < nbits; k++) begin
            state = state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
            bits  = {bits[30:0], state[0]};
        end
        return bits;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input word_t got, input word_t want);
        stop_with_failure($sformatf("MISMATCH at %0t ns: %s is %h, expected %h",
                                    $time, name, got, want));
    endtask

    ////////////////////
    // reference models
    ////////////////////

    // in-order result straight from the instruction fields
    function automatic word_t golden_result(input inst_t i, input word_t pc_v);
        logic [31:0] bits;
        word_t       a;
        word_t       b;
        logic        alt;
        bits = i;
        a    = gold_regs[i.rs1];
        b    = (i.opcode == OP_REG) ? gold_regs[i.rs2] : {{20{bits[31]}}, bits[31:20]};
        alt  = (i.funct7 == F7_ALT);
        if (i.opcode == OP_LUI) begin
            return {bits[31:12], 12'b0};
        end
        if (i.opcode == OP_AUIPC) begin
            return pc_v + {bits[31:12], 12'b0};
        end
        case (i.funct3)
            3'b000:  return (i.opcode == OP_REG && alt) ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic word_t fu_compute(input alu_func_t f, input word_t a, input word_t b);
        case (f)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return word_t'($signed(a) >>> b[4:0]);
            default:  return '0;
        endcase
    endfunction

    // registers kept to x0..x7 so dependences stay frequent
    function automatic inst_t random_inst(input int index);
        inst_t       i;
        logic [2:0]  kind;
        logic [11:0] imm;
        i        = '0;
        i.rd     = reg_idx_t'(draw(stim_lfsr, 3));
        i.rs1    = reg_idx_t'(draw(stim_lfsr, 3));
        kind     = 3'(draw(stim_lfsr, 3));
        i.funct3 = 3'(draw(stim_lfsr, 3));
        if (index < 7) begin
            // addi xN, x0, imm so every source has a known value
            i.opcode        = OP_IMM;
            i.funct3        = F3_ADD;
            i.rs1           = ZERO_REG;
            i.rd            = reg_idx_t'(index + 1);
            {i.funct7, i.rs2} = 12'(draw(stim_lfsr, 12));
        end else if (kind == 3'd0 || kind == 3'd1) begin
            i.opcode = (kind == 3'd0) ? OP_LUI : OP_AUIPC;
            {i.funct7, i.rs2, i.rs1, i.funct3} = 20'(draw(stim_lfsr, 20));
        end else if (kind <= 3'd4) begin
            i.opcode = OP_IMM;
            imm      = 12'(draw(stim_lfsr, 12));
            if (i.funct3 == F3_SLL) begin
                imm[11:5] = F7_BASE;
            end else if (i.funct3 == F3_SR) begin
                imm[11:5] = draw(stim_lfsr, 1) ? F7_ALT : F7_BASE;
            end
            {i.funct7, i.rs2} = imm;
        end else begin
            i.opcode = OP_REG;
            i.rs2    = reg_idx_t'(draw(stim_lfsr, 3));
            if ((i.funct3 == F3_ADD || i.funct3 == F3_SR) && draw(stim_lfsr, 1)) begin
                i.funct7 = F7_ALT;
            end
        end
        return i;
    endfunction

    task automatic accept_golden(input inst_t i, input word_t pc_v);
        word_t value;
        value = golden_result(i, pc_v);
        exp_reg.push_back(i.rd);
        exp_value.push_back(value);
        if (i.rd != ZERO_REG) begin
            gold_regs[i.rd] = value;
        end
        accepted++;
    endtask

    ////////////////////
    // run control
    ////////////////////

    always @(posedge clock) begin
        if (reset) begin
            cycle <= 0;
        end else begin
            cycle <= cycle + 1;
        end
        if (cycle >= CYCLE_LIMIT) begin
            stop_with_failure($sformatf("timeout: run still busy after %0d cycles", cycle));
        end
    end

    always @(negedge clock) begin
        if (UUT.protocol_checks.failures != 0) begin
            stop_with_failure("a bound protocol assertion failed");
        end
    end

    // functional unit whose results may leave on the cdb out of order
    always @(negedge clock) begin
        int pick;
        pick = -1;
        if (cycle > 0) begin
            for (int k = 0; k < fu_due.size(); k++) begin
                if (pick < 0 && fu_due[k] <= cycle) begin
                    pick = k;
                end
            end
        end
        if (pick >= 0) begin
            cdb_valid = 1'b1;
            cdb_tag   = fu_tag[pick];
            cdb_value = fu_value[pick];
            fu_tag.delete(pick);
            fu_value.delete(pick);
            fu_due.delete(pick);
        end else begin
            cdb_valid = 1'b0;
        end
        if (cycle > 0) begin
            fu_busy = (draw(fu_lfsr, 2) == 0);
            // issue_valid is registered and holds until the next rising edge
            if (issue_valid && !fu_busy) begin
                fu_tag.push_back(issue_tag);
                fu_value.push_back(fu_compute(issue_func, issue_opa, issue_opb));
                fu_due.push_back(cycle + 1 + int'(draw(fu_lfsr, 2)));
            end
        end
    end

    always @(negedge clock) begin
        if (cycle > 0 && retire_valid) begin
            assert (exp_reg.size() != 0)
                else stop_with_failure("retirement with no accepted instruction outstanding");
            assert (retire_reg == exp_reg[0])
                else report_mismatch("retire_reg", word_t'(retire_reg), word_t'(exp_reg[0]));
            assert (retire_value == exp_value[0])
                else report_mismatch("retire_value", retire_value, exp_value[0]);
            exp_reg.pop_front();
            exp_value.pop_front();
            retired++;
        end
    end

    initial begin
        inst_t next;
        stim_lfsr  = 32'h75568eb0;
        fu_lfsr    = draw(stim_lfsr, 32);
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        pc         = '0;
        fu_busy    = 1'b0;
        cdb_valid  = 1'b0;
        cdb_tag    = '0;
        cdb_value  = '0;
        accepted   = 0;
        retired    = 0;
        for (int r = 0; r < NUM_ARCH_REGS; r++) begin
            gold_regs[r] = '0;
        end
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        for (int n = 0; n < NUM_INSTS; n++) begin
            // occasional fetch bubble
            while (draw(stim_lfsr, 3) == 0) begin
                inst_valid = 1'b0;
                @(negedge clock);
            end
            next       = random_inst(n);
            inst       = next;
            pc         = 32'h0000_1000 + 32'(4 * n);
            inst_valid = 1'b1;
            // stall only moves at rising edges, so its value here decides the next edge
            while (stall) begin
                @(negedge clock);
            end
            accept_golden(next, pc);
            @(negedge clock);
        end
        inst_valid = 1'b0;

        while (retired < NUM_INSTS) begin
            @(negedge clock);
        end
        // extra cycles catch a duplicated retirement
        repeat (20) @(negedge clock);
        if (retired == accepted && exp_reg.size() == 0
                && UUT.protocol_checks.failures == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            stop_with_failure($sformatf("accepted %0d, retired %0d, %0d assertion failures",
                                        accepted, retired, UUT.protocol_checks.failures));
        end
    end

endmodule

//--- ooo_dispatch.f
verilog/rv32_isa_pkg.sv
verilog/ooo_pkg.sv
verilog/dispatch_if.sv
verilog/rob_lookup_if.sv
verilog/decoder.sv
verilog/map_table.sv
verilog/regfile.sv
verilog/reorder_buffer.sv
verilog/reservation_station.sv
verilog/stage_dispatch.sv
bench/stage_dispatch_assertions.sv
bench/stage_dispatch_tb.sv

//--- verilog/decoder.sv
`timescale 1ns/1ns

module decoder (
    input  rv32_isa_pkg::inst_t       inst,
    input  logic                      valid,
    output rv32_isa_pkg::opa_select_t opa_select,
    output rv32_isa_pkg::opb_select_t opb_select,
    output rv32_isa_pkg::alu_func_t   alu_func,
    output logic                      has_dest
);
    import rv32_isa_pkg::*;

    alu_func_t base_func;
    logic      alt;
    logic      shift;
    logic      legal;

    assign alt   = (inst.funct7 == F7_ALT);
    assign shift = (inst.funct3 == F3_SLL) || (inst.funct3 == F3_SR);

    // funct3 mapping shared by the register and immediate forms
    always_comb begin
        case (inst.funct3)
            F3_ADD:  base_func = ALU_ADD;
            F3_SLL:  base_func = ALU_SLL;
            F3_SLT:  base_func = ALU_SLT;
            F3_SLTU: base_func = ALU_SLTU;
            F3_XOR:  base_func = ALU_XOR;
            F3_SR:   base_func = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   base_func = ALU_OR;
            default: base_func = ALU_AND;
        endcase
    end

    always_comb begin
        legal      = 1'b1;
        opa_select = OPA_IS_RS1;
        opb_select = OPB_IS_RS2;
        alu_func   = base_func;
        case (inst.opcode)
            OP_LUI: begin
                opa_select = OPA_IS_ZERO;
                opb_select = OPB_IS_U_IMM;
                alu_func   = ALU_ADD;
            end
            OP_AUIPC: begin
                opa_select = OPA_IS_PC;
                opb_select = OPB_IS_U_IMM;
                alu_func   = ALU_ADD;
            end
            OP_IMM: begin
                opb_select = OPB_IS_I_IMM;
                // shift amounts only allow the base or SRAI funct7
                legal = !shift || (inst.funct7 == F7_BASE) || (alt && inst.funct3 == F3_SR);
            end
            OP_REG: begin
                legal = (inst.funct7 == F7_BASE)
                        || (alt && (inst.funct3 == F3_ADD || inst.funct3 == F3_SR));
                if (alt && inst.funct3 == F3_ADD) begin
                    alu_func = ALU_SUB;
                end
            end
            default: legal = 1'b0;
        endcase
        // nop: 0 + imm, no sources to wait on
        if (!legal) begin
            opa_select = OPA_IS_ZERO;
            opb_select = OPB_IS_I_IMM;
            alu_func   = ALU_ADD;
        end
    end

    assign has_dest = valid && legal && (inst.rd != 5'd0);

endmodule

//--- verilog/dispatch_if.sv
`timescale 1ns/1ns

interface dispatch_if #(
    parameter int ROB_DEPTH = 8,
    localparam int TAG_W = $clog2(ROB_DEPTH)
);
    import ooo_pkg::*;
    import rv32_isa_pkg::*;

    logic             load;
    logic [TAG_W-1:0] tag;
    // operand value, or the awaited tag while not ready
    word_t            opa;
    logic             opa_ready;
    word_t            opb;
    logic             opb_ready;
    alu_func_t        func;

    modport source (output load, tag, opa, opa_ready, opb, opb_ready, func);
    modport sink (input load, tag, opa, opa_ready, opb, opb_ready, func);

endinterface

//--- verilog/map_table.sv
`timescale 1ns/1ns

module map_table #(
    parameter int ROB_DEPTH = 8,
    localparam int TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic              clock,
    input  logic              reset,
    input  ooo_pkg::reg_idx_t rs1_addr,
    input  ooo_pkg::reg_idx_t rs2_addr,
    output logic [TAG_W-1:0]  rs1_tag,
    output logic [TAG_W-1:0]  rs2_tag,
    output logic              rs1_renamed,
    output logic              rs2_renamed,
    input  logic              rename_en,
    input  ooo_pkg::reg_idx_t rename_reg,
    input  logic [TAG_W-1:0]  rename_tag,
    input  logic              retire_en,
    input  ooo_pkg::reg_idx_t retire_reg,
    input  logic [TAG_W-1:0]  retire_tag
);
    import ooo_pkg::*;

    logic [NUM_ARCH_REGS-1:0] renamed;
    logic [TAG_W-1:0]         tags [NUM_ARCH_REGS];

    assign rs1_renamed = renamed[rs1_addr];
    assign rs2_renamed = renamed[rs2_addr];
    assign rs1_tag     = tags[rs1_addr];
    assign rs2_tag     = tags[rs2_addr];

    always_ff @(posedge clock) begin
        if (reset) begin
            renamed <= '0;
        end else begin
            // only drop the mapping if no younger writer took over
            if (retire_en && tags[retire_reg] == retire_tag) begin
                renamed[retire_reg] <= 1'b0;
            end
            if (rename_en) begin
                renamed[rename_reg] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rename_en) begin
            tags[rename_reg] <= rename_tag;
        end
    end

endmodule

//--- verilog/ooo_pkg.sv
package ooo_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;

    // architectural register space
    localparam int NUM_ARCH_REGS = 32;

    typedef logic [$clog2(NUM_ARCH_REGS)-1:0] reg_idx_t;

    localparam reg_idx_t ZERO_REG = '0;

endpackage

//--- verilog/regfile.sv
`timescale 1ns/1ns

module regfile (
    input  logic              clock,
    input  ooo_pkg::reg_idx_t read_idx_1,
    input  ooo_pkg::reg_idx_t read_idx_2,
    output ooo_pkg::word_t    read_out_1,
    output ooo_pkg::word_t    read_out_2,
    input  logic              write_en,
    input  ooo_pkg::reg_idx_t write_idx,
    input  ooo_pkg::word_t    write_data
);
    import ooo_pkg::*;

    word_t regs [NUM_ARCH_REGS];

    // x0 reads as zero whatever is stored there
    assign read_out_1 = (read_idx_1 == ZERO_REG) ? '0 : regs[read_idx_1];
    assign read_out_2 = (read_idx_2 == ZERO_REG) ? '0 : regs[read_idx_2];

    always_ff @(posedge clock) begin
        if (write_en) begin
            regs[write_idx] <= write_data;
        end
    end

endmodule

//--- verilog/reorder_buffer.sv
`timescale 1ns/1ns

module reorder_buffer #(
    parameter int ROB_DEPTH = 8,
    localparam int TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   alloc_en,
    input  ooo_pkg::reg_idx_t      alloc_reg,
    input  logic                   alloc_has_dest,
    output logic [TAG_W-1:0]       alloc_tag,
    output logic                   full,
    input  logic                   cdb_valid,
    input  logic [TAG_W-1:0]       cdb_tag,
    input  ooo_pkg::word_t         cdb_value,
    rob_lookup_if.responder        lookup,
    output logic                   retire_valid,
    output ooo_pkg::reg_idx_t      retire_reg,
    output ooo_pkg::word_t         retire_value,
    output logic                   retire_write,
    output logic [TAG_W-1:0]       retire_tag
);
    import ooo_pkg::*;

    reg_idx_t             dest_reg [ROB_DEPTH];
    word_t                value [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] dest_valid;
    logic [ROB_DEPTH-1:0] done;
    logic [TAG_W-1:0]     head;
    logic [TAG_W-1:0]     tail;
    logic [TAG_W:0]       count;

    assign alloc_tag = tail;
    assign full      = (count == (TAG_W+1)'(ROB_DEPTH));

    ////////////////////
    // operand lookup
    ////////////////////

    assign lookup.done1  = done[lookup.tag1];
    assign lookup.done2  = done[lookup.tag2];
    assign lookup.value1 = value[lookup.tag1];
    assign lookup.value2 = value[lookup.tag2];

    ////////////////////
    // retire from head
    ////////////////////

    // count guards against a stale done bit once the buffer drains
    assign retire_valid = (count != '0) && done[head];
    assign retire_reg   = dest_reg[head];
    assign retire_value = value[head];
    assign retire_write = dest_valid[head];
    assign retire_tag   = head;

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            if (cdb_valid) begin
                done[cdb_tag] <= 1'b1;
            end
            if (alloc_en) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (retire_valid) begin
                head <= head + 1'b1;
            end
            count <= count + (TAG_W+1)'(alloc_en) - (TAG_W+1)'(retire_valid);
        end
    end

    always_ff @(posedge clock) begin
        if (cdb_valid) begin
            value[cdb_tag] <= cdb_value;
        end
        if (alloc_en) begin
            dest_reg[tail]   <= alloc_reg;
            dest_valid[tail] <= alloc_has_dest;
        end
    end

endmodule

//--- verilog/reservation_station.sv
`timescale 1ns/1ns

module reservation_station #(
    parameter int ROB_DEPTH = 8,
    localparam int TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic                    clock,
    input  logic                    reset,
    dispatch_if.sink                dispatch,
    input  logic                    cdb_valid,
    input  logic [TAG_W-1:0]        cdb_tag,
    input  ooo_pkg::word_t          cdb_value,
    input  logic                    fu_busy,
    output logic                    busy,
    output logic                    issue_valid,
    output logic [TAG_W-1:0]        issue_tag,
    output ooo_pkg::word_t          issue_opa,
    output ooo_pkg::word_t          issue_opb,
    output rv32_isa_pkg::alu_func_t issue_func
);
    import ooo_pkg::*;
    import rv32_isa_pkg::*;

    logic [TAG_W-1:0] tag_q;
    word_t            opa_q;
    word_t            opb_q;
    logic             opa_ready;
    logic             opb_ready;
    alu_func_t        func_q;

    assign issue_valid = busy && opa_ready && opb_ready;
    assign issue_tag   = tag_q;
    assign issue_opa   = opa_q;
    assign issue_opb   = opb_q;
    assign issue_func  = func_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (dispatch.load) begin
            busy <= 1'b1;
        end else if (issue_valid && !fu_busy) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (dispatch.load) begin
            tag_q     <= dispatch.tag;
            opa_q     <= dispatch.opa;
            opa_ready <= dispatch.opa_ready;
            opb_q     <= dispatch.opb;
            opb_ready <= dispatch.opb_ready;
            func_q    <= dispatch.func;
        end else begin
            // wakeup, waiting operands hold their tag in the low bits
            if (busy && !opa_ready && cdb_valid && opa_q[TAG_W-1:0] == cdb_tag) begin
                opa_q     <= cdb_value;
                opa_ready <= 1'b1;
            end
            if (busy && !opb_ready && cdb_valid && opb_q[TAG_W-1:0] == cdb_tag) begin
                opb_q     <= cdb_value;
                opb_ready <= 1'b1;
            end
        end
    end

endmodule

//--- verilog/rob_lookup_if.sv
`timescale 1ns/1ns

interface rob_lookup_if #(
    parameter int ROB_DEPTH = 8,
    localparam int TAG_W = $clog2(ROB_DEPTH)
);
    import ooo_pkg::*;

    logic [TAG_W-1:0] tag1;
    logic [TAG_W-1:0] tag2;
    logic             done1;
    logic             done2;
    word_t            value1;
    word_t            value2;

    modport requester (output tag1, tag2, input done1, done2, value1, value2);
    modport responder (input tag1, tag2, output done1, done2, value1, value2);

endinterface

//--- verilog/rv32_isa_pkg.sv
package rv32_isa_pkg;

    // base instruction word, R-type field view
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_t;

    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_REG   = 7'b0110011;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND,
        ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_func_t;

    typedef enum logic [1:0] {
        OPA_IS_RS1, OPA_IS_PC, OPA_IS_ZERO
    } opa_select_t;

    typedef enum logic [1:0] {
        OPB_IS_RS2, OPB_IS_I_IMM, OPB_IS_U_IMM
    } opb_select_t;

endpackage

//--- verilog/stage_dispatch.sv
`timescale 1ns/1ns

module stage_dispatch #(
    parameter int ROB_DEPTH = 8,
    localparam int TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    inst_valid,
    input  rv32_isa_pkg::inst_t     inst,
    input  ooo_pkg::word_t          pc,
    input  logic                    fu_busy,
    input  logic                    cdb_valid,
    input  logic [TAG_W-1:0]        cdb_tag,
    input  ooo_pkg::word_t          cdb_value,
    output logic                    stall,
    output logic                    issue_valid,
    output logic [TAG_W-1:0]        issue_tag,
    output ooo_pkg::word_t          issue_opa,
    output ooo_pkg::word_t          issue_opb,
    output rv32_isa_pkg::alu_func_t issue_func,
    output logic                    retire_valid,
    output ooo_pkg::reg_idx_t       retire_reg,
    output ooo_pkg::word_t          retire_value
);
    import ooo_pkg::*;
    import rv32_isa_pkg::*;

    typedef struct packed {
        logic  ready;
        word_t value;
    } operand_t;

    opa_select_t      opa_select;
    opb_select_t      opb_select;
    alu_func_t        alu_func;
    logic             has_dest;
    logic [XLEN-1:0]  inst_bits;
    word_t            imm_i;
    word_t            imm_u;
    reg_idx_t         dest_idx;
    logic             dispatch;
    logic             rob_full;
    logic             rs_busy;
    logic [TAG_W-1:0] alloc_tag;
    logic [TAG_W-1:0] rs1_tag;
    logic [TAG_W-1:0] rs2_tag;
    logic             rs1_renamed;
    logic             rs2_renamed;
    word_t            rs1_value;
    word_t            rs2_value;
    operand_t         src1;
    operand_t         src2;
    logic             retire_write;
    logic [TAG_W-1:0] retire_tag;

    dispatch_if   #(.ROB_DEPTH(ROB_DEPTH)) dif ();
    rob_lookup_if #(.ROB_DEPTH(ROB_DEPTH)) lookup ();

    // regfile, then same-cycle CDB, then completed ROB entry, else wait on tag
    function automatic operand_t resolve_src(
        input logic             renamed,
        input logic [TAG_W-1:0] tag,
        input word_t            rf_value,
        input logic             bus_valid,
        input logic [TAG_W-1:0] bus_tag,
        input word_t            bus_value,
        input logic             rob_done,
        input word_t            rob_value
    );
        operand_t op;
        op.ready = 1'b1;
        if (!renamed) begin
            op.value = rf_value;
        end else if (bus_valid && bus_tag == tag) begin
            op.value = bus_value;
        end else if (rob_done) begin
            op.value = rob_value;
        end else begin
            op.value = word_t'(tag);
            op.ready = 1'b0;
        end
        return op;
    endfunction

    ////////////////////
    // decode and stall
    ////////////////////

    assign inst_bits = inst;
    assign imm_i     = {{(XLEN-12){inst_bits[31]}}, inst_bits[31:20]};
    assign imm_u     = {inst_bits[31:12], 12'b0};
    assign dest_idx  = has_dest ? inst.rd : ZERO_REG;

    assign stall    = rob_full || rs_busy;
    assign dispatch = inst_valid && !stall;

    ////////////////////
    // operand select
    ////////////////////

    assign lookup.tag1 = rs1_tag;
    assign lookup.tag2 = rs2_tag;
    assign src1 = resolve_src(rs1_renamed, rs1_tag, rs1_value, cdb_valid, cdb_tag, cdb_value,
                              lookup.done1, lookup.value1);
    assign src2 = resolve_src(rs2_renamed, rs2_tag, rs2_value, cdb_valid, cdb_tag, cdb_value,
                              lookup.done2, lookup.value2);

    always_comb begin
        dif.opa       = src1.value;
        dif.opa_ready = src1.ready;
        case (opa_select)
            OPA_IS_PC:   dif.opa = pc;
            OPA_IS_ZERO: dif.opa = '0;
            default:     dif.opa = src1.value;
        endcase
        if (opa_select != OPA_IS_RS1) begin
            dif.opa_ready = 1'b1;
        end
    end

    always_comb begin
        dif.opb       = src2.value;
        dif.opb_ready = src2.ready;
        case (opb_select)
            OPB_IS_I_IMM: dif.opb = imm_i;
            OPB_IS_U_IMM: dif.opb = imm_u;
            default:      dif.opb = src2.value;
        endcase
        if (opb_select != OPB_IS_RS2) begin
            dif.opb_ready = 1'b1;
        end
    end

    assign dif.load = dispatch;
    assign dif.tag  = alloc_tag;
    assign dif.func = alu_func;

    decoder decoder_0 (
        .inst       (inst),
        .valid      (inst_valid),
        .opa_select (opa_select),
        .opb_select (opb_select),
        .alu_func   (alu_func),
        .has_dest   (has_dest)
    );

    map_table #(.ROB_DEPTH(ROB_DEPTH)) map_table_0 (
        .clock       (clock),
        .reset       (reset),
        .rs1_addr    (inst.rs1),
        .rs2_addr    (inst.rs2),
        .rs1_tag     (rs1_tag),
        .rs2_tag     (rs2_tag),
        .rs1_renamed (rs1_renamed),
        .rs2_renamed (rs2_renamed),
        .rename_en   (dispatch && has_dest),
        .rename_reg  (dest_idx),
        .rename_tag  (alloc_tag),
        .retire_en   (retire_valid && retire_write),
        .retire_reg  (retire_reg),
        .retire_tag  (retire_tag)
    );

    regfile regfile_0 (
        .clock      (clock),
        .read_idx_1 (inst.rs1),
        .read_idx_2 (inst.rs2),
        .read_out_1 (rs1_value),
        .read_out_2 (rs2_value),
        .write_en   (retire_valid && retire_write),
        .write_idx  (retire_reg),
        .write_data (retire_value)
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) reorder_buffer_0 (
        .clock          (clock),
        .reset          (reset),
        .alloc_en       (dispatch),
        .alloc_reg      (dest_idx),
        .alloc_has_dest (has_dest),
        .alloc_tag      (alloc_tag),
        .full           (rob_full),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value),
        .lookup         (lookup.responder),
        .retire_valid   (retire_valid),
        .retire_reg     (retire_reg),
        .retire_value   (retire_value),
        .retire_write   (retire_write),
        .retire_tag     (retire_tag)
    );

    reservation_station #(.ROB_DEPTH(ROB_DEPTH)) reservation_station_0 (
        .clock       (clock),
        .reset       (reset),
        .dispatch    (dif.sink),
        .cdb_valid   (cdb_valid),
        .cdb_tag     (cdb_tag),
        .cdb_value   (cdb_value),
        .fu_busy     (fu_busy),
        .busy        (rs_busy),
        .issue_valid (issue_valid),
        .issue_tag   (issue_tag),
        .issue_opa   (issue_opa),
        .issue_opb   (issue_opb),
        .issue_func  (issue_func)
    );

endmodule
